/* Makefile */
# Verilator build and run of the external bus testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f files.f --top-module extBusTb -o extBusTb
	./obj_dir/extBusTb | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bb1Pkg.sv */
// ############################################################################
// Shared definitions for the external bus register file.
// Widths of the data word, tag and slice, the register index type, and the
// two port-control structs: busCtl_t in true polarity for the bus side,
// pinCtl_t in chip pin polarity for the slices.
// Reference these by scoped name, e.g. bb1Pkg::busCtl_t.
// ############################################################################

package bb1Pkg;

    // Word geometry
    localparam int wordW   = 64;              // Data bits
    localparam int tagW    = 8;               // Tag bits
    localparam int fullW   = wordW + tagW;    // Full register, 72 bits
    localparam int nibbleW = 4;               // One RAM slice

    // Four registers per slice
    typedef logic [1:0] regAddr_t;

    // Port control as seen from outside the bus
    typedef struct packed {
        regAddr_t addr;     // Register select
        logic     en;       // Port enable, active high
        logic     wr;       // Write, active high
    } busCtl_t;

    // Port control at the chip pins
    typedef struct packed {
        regAddr_t addr;     // Register select
        logic     nEn;      // Port enable, active low
        logic     nWr;      // Write, active low
    } pinCtl_t;

    // Register 1 holds the instruction word, read through port C
    localparam regAddr_t instrReg = 2'd1;

    // Register 2 supplies the data tag on the A tag half
    localparam regAddr_t tagReg = 2'd2;

endpackage

/* bb1Slice.sv */
// ############################################################################
// One 4-bit slice of the register file, shaped like a K1802BB1 four-port RAM.
// Four words of one nibble each, ports A, B, C and X.
// All pins follow the chip: data in and out are inverted, enable and write
// are active low. Reads are combinational, writes land on the rising clk.
// Same-register writes in one cycle resolve X over B over A over C.
// ############################################################################
`timescale 1ns/10ps

module bb1Slice (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [bb1Pkg::nibbleW-1:0] nDA,     // Inverted data in
    input  logic [bb1Pkg::nibbleW-1:0] nDB,
    input  logic [bb1Pkg::nibbleW-1:0] nDC,
    input  logic [bb1Pkg::nibbleW-1:0] nDX,

    output logic [bb1Pkg::nibbleW-1:0] nQA,     // Inverted data out
    output logic [bb1Pkg::nibbleW-1:0] nQB,
    output logic [bb1Pkg::nibbleW-1:0] nQC,
    output logic [bb1Pkg::nibbleW-1:0] nQX,

    input  bb1Pkg::pinCtl_t            pinA,
    input  bb1Pkg::pinCtl_t            pinB,
    input  bb1Pkg::pinCtl_t            pinC,
    input  bb1Pkg::pinCtl_t            pinX
);

    localparam int numRegs = 4;

    // Contents kept in true polarity
    logic [bb1Pkg::nibbleW-1:0] mem     [numRegs];
    logic [bb1Pkg::nibbleW-1:0] memNext [numRegs];

    // Per-port strobes
    logic wrA;
    logic wrB;
    logic wrC;
    logic wrX;
    logic rdA;
    logic rdB;
    logic rdC;
    logic rdX;

    assign wrA = ~pinA.nEn & ~pinA.nWr;
    assign wrB = ~pinB.nEn & ~pinB.nWr;
    assign wrC = ~pinC.nEn & ~pinC.nWr;
    assign wrX = ~pinX.nEn & ~pinX.nWr;

    // A port drives data only when enabled and not writing
    assign rdA = ~pinA.nEn & pinA.nWr;
    assign rdB = ~pinB.nEn & pinB.nWr;
    assign rdC = ~pinC.nEn & pinC.nWr;
    assign rdX = ~pinX.nEn & pinX.nWr;

    // Next contents of each word. Later checks override earlier ones,
    // which gives the port priority.
    always_comb begin
        for (int i = 0; i < numRegs; i++) begin
            memNext[i] = mem[i];
            if (wrC && pinC.addr == bb1Pkg::regAddr_t'(i))
                memNext[i] = ~nDC;
            if (wrA && pinA.addr == bb1Pkg::regAddr_t'(i))
                memNext[i] = ~nDA;
            if (wrB && pinB.addr == bb1Pkg::regAddr_t'(i))
                memNext[i] = ~nDB;
            if (wrX && pinX.addr == bb1Pkg::regAddr_t'(i))
                memNext[i] = ~nDX;      // X always wins
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                mem[i] <= memNext[i];
            end
        end
    end

    // Idle pins float high on the chip, i.e. read as true zero
    assign nQA = rdA ? ~mem[pinA.addr] : '1;
    assign nQB = rdB ? ~mem[pinB.addr] : '1;
    assign nQC = rdC ? ~mem[pinC.addr] : '1;
    assign nQX = rdX ? ~mem[pinX.addr] : '1;

endmodule

/* extBus.sv */
// ############################################################################
// External bus interface of the processor: a four-word, four-port register
// file of 72-bit words (64 data bits plus an 8-bit tag), built from eighteen
// bb1Slice nibbles. The outside sees true data and active-high controls.
// Port C is wired to register 1 and gives iword and itag. The A tag half
// always reads register 2 and gives dtag. Port B writes tags only with tagEnB.
// Reads are combinational; a write is visible after the next rising clk.
// ############################################################################
`timescale 1ns/10ps

module extBus (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [bb1Pkg::wordW-1:0] dA,        // A carries data bits only
    input  logic [bb1Pkg::fullW-1:0] dB,
    input  logic [bb1Pkg::fullW-1:0] dX,

    input  bb1Pkg::busCtl_t          ctlA,
    input  bb1Pkg::busCtl_t          ctlB,
    input  bb1Pkg::busCtl_t          ctlX,
    input  logic                     tagEnB,    // Enables the B tag half

    output logic [bb1Pkg::wordW-1:0] qA,
    output logic [bb1Pkg::fullW-1:0] qB,
    output logic [bb1Pkg::fullW-1:0] qX,

    output logic [bb1Pkg::wordW-1:0] iword,     // Register 1 data
    output logic [bb1Pkg::tagW-1:0]  itag,      // Register 1 tag
    output logic [bb1Pkg::tagW-1:0]  dtag       // Register 2 tag
);

    localparam int dataSlices = bb1Pkg::wordW / bb1Pkg::nibbleW;   // 16
    localparam int numSlices  = bb1Pkg::fullW / bb1Pkg::nibbleW;   // 18

    // True-polarity control to chip pin polarity
    function automatic bb1Pkg::pinCtl_t toPin(input bb1Pkg::busCtl_t ctl);
        bb1Pkg::pinCtl_t pin;
        pin.addr = ctl.addr;
        pin.nEn  = ~ctl.en;
        pin.nWr  = ~ctl.wr;
        return pin;
    endfunction

    bb1Pkg::busCtl_t ctlBTag;       // B control for the tag slices

    bb1Pkg::pinCtl_t pinA;
    bb1Pkg::pinCtl_t pinB;
    bb1Pkg::pinCtl_t pinX;
    bb1Pkg::pinCtl_t pinC;
    bb1Pkg::pinCtl_t pinATag;
    bb1Pkg::pinCtl_t pinBTag;

    // Inverted data on the slice side
    logic [bb1Pkg::fullW-1:0] nDA;
    logic [bb1Pkg::fullW-1:0] nDB;
    logic [bb1Pkg::fullW-1:0] nDC;
    logic [bb1Pkg::fullW-1:0] nDX;
    logic [bb1Pkg::fullW-1:0] nQA;
    logic [bb1Pkg::fullW-1:0] nQB;
    logic [bb1Pkg::fullW-1:0] nQC;
    logic [bb1Pkg::fullW-1:0] nQX;

    assign ctlBTag.addr = ctlB.addr;
    assign ctlBTag.en   = tagEnB;
    assign ctlBTag.wr   = ctlB.wr;

    assign pinA    = toPin(ctlA);
    assign pinB    = toPin(ctlB);
    assign pinX    = toPin(ctlX);
    assign pinBTag = toPin(ctlBTag);

    // C reads register 1 forever
    assign pinC.addr = bb1Pkg::instrReg;
    assign pinC.nEn  = 1'b0;
    assign pinC.nWr  = 1'b1;

    // A tag half reads register 2 forever
    assign pinATag.addr = bb1Pkg::tagReg;
    assign pinATag.nEn  = 1'b0;
    assign pinATag.nWr  = 1'b1;

    // Input inversion. Unused pins sit at all ones.
    assign nDA = {{bb1Pkg::tagW{1'b1}}, ~dA};
    assign nDB = ~dB;
    assign nDC = '1;
    assign nDX = ~dX;

    for (genvar s = 0; s < numSlices; s++) begin : gSlice
        localparam int lo = s * bb1Pkg::nibbleW;

        bb1Pkg::pinCtl_t sliceA;
        bb1Pkg::pinCtl_t sliceB;

        if (s < dataSlices) begin : gData
            assign sliceA = pinA;
            assign sliceB = pinB;
        end else begin : gTag
            assign sliceA = pinATag;    // Tag never written from A
            assign sliceB = pinBTag;
        end

        bb1Slice uSlice (
            .clk  (clk),
            .rst  (rst),
            .nDA  (nDA[lo +: bb1Pkg::nibbleW]),
            .nDB  (nDB[lo +: bb1Pkg::nibbleW]),
            .nDC  (nDC[lo +: bb1Pkg::nibbleW]),
            .nDX  (nDX[lo +: bb1Pkg::nibbleW]),
            .nQA  (nQA[lo +: bb1Pkg::nibbleW]),
            .nQB  (nQB[lo +: bb1Pkg::nibbleW]),
            .nQC  (nQC[lo +: bb1Pkg::nibbleW]),
            .nQX  (nQX[lo +: bb1Pkg::nibbleW]),
            .pinA (sliceA),
            .pinB (sliceB),
            .pinC (pinC),
            .pinX (pinX)
        );
    end

    // Output inversion and word/tag split
    assign qA    = ~nQA[bb1Pkg::wordW-1:0];
    assign dtag  = ~nQA[bb1Pkg::fullW-1:bb1Pkg::wordW];
    assign qB    = ~nQB;
    assign qX    = ~nQX;
    assign iword = ~nQC[bb1Pkg::wordW-1:0];
    assign itag  = ~nQC[bb1Pkg::fullW-1:bb1Pkg::wordW];

endmodule

/* extBusTests.svh */
// ############################################################################
// Directed tests for the external bus register file.
// Included into the testbench module; each task sets up the next cycle's
// controls and data, then calls step() which drives, checks and updates the
// reference model. Extra checks compare against values the test wrote.
// ############################################################################
`ifndef EXT_BUS_TESTS_SVH
`define EXT_BUS_TESTS_SVH

    // Fill all registers, reset with a write pending, then read everything
    task automatic checkReset();
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < numRegs; i++) begin
            idleControls();
            cX = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b1);
            vX = randomWord();
            step();
        end
        idleControls();
        doRst = 1'b1;
        cB    = makeCtl(bb1Pkg::instrReg, 1'b1, 1'b1);   // Ignored under reset
        tEn   = 1'b1;
        vB    = randomWord();
        step();
        idleControls();
        step();
        checkField("iword", word_t'(iword), '0);
        checkField("itag", word_t'(itag), '0);
        checkField("dtag", word_t'(dtag), '0);
        for (int i = 0; i < numRegs; i++) begin
            idleControls();
            cA  = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b0);
            cB  = cA;
            cX  = cA;
            tEn = 1'b1;
            step();
        end
        finishTest("reset", errBefore);
    endtask

    // Write each address from each port, read back on all three
    task automatic checkWriteRead();
        int    errBefore;
        word_t w;
        errBefore = errors;
        for (int p = 0; p < 3; p++) begin
            for (int i = 0; i < numRegs; i++) begin
                w = randomWord();
                idleControls();
                case (p)
                    0: begin
                        cX = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b1);
                        vX = w;
                    end
                    1: begin
                        cB  = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b1);
                        vB  = w;
                        tEn = 1'b1;
                    end
                    default: begin     // A last, so the tags it keeps are random
                        cA = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b1);
                        vA = w[wordW-1:0];
                    end
                endcase
                step();
                idleControls();
                cA  = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b0);
                cB  = cA;
                cX  = cA;
                tEn = 1'b1;
                step();
                checkField("qA", word_t'(qA), word_t'(w[wordW-1:0]));
            end
        end
        finishTest("write/read", errBefore);
    endtask

    task automatic checkTags();
        int               errBefore;
        word_t            w;
        bb1Pkg::regAddr_t addr;
        errBefore = errors;
        for (int k = 0; k < 5; k++) begin
            w    = randomWord();
            addr = k < 4 ? (k < 2 ? bb1Pkg::tagReg : bb1Pkg::instrReg) : bb1Pkg::tagReg;
            idleControls();
            // Alternate tag enable; the last pass writes the tag alone
            cB  = makeCtl(addr, k < 4, 1'b1);
            tEn = (k % 2 == 1) || (k == 4);
            vB  = w;
            step();
            idleControls();
            cX = makeCtl(addr, 1'b1, 1'b0);
            step();
            if (k == 1 || k == 4)
                checkField("dtag", word_t'(dtag), word_t'(w[fullW-1:wordW]));
            if (k == 3)
                checkField("itag", word_t'(itag), word_t'(w[fullW-1:wordW]));
        end
        finishTest("tags", errBefore);
    endtask

    task automatic checkSimultaneous();
        int    errBefore;
        word_t w;
        errBefore = errors;
        idleControls();
        cA  = makeCtl(2'd3, 1'b1, 1'b1);
        cB  = cA;
        cX  = cA;
        tEn = 1'b1;
        vA  = wordW'(randomWord());
        vB  = randomWord();
        vX  = randomWord();
        w   = vX;
        step();
        idleControls();
        cX = makeCtl(2'd3, 1'b1, 1'b0);
        step();
        checkField("qX", qX, w);
        // Three distinct targets in one cycle
        idleControls();
        cA  = makeCtl(2'd0, 1'b1, 1'b1);
        cB  = makeCtl(2'd1, 1'b1, 1'b1);
        cX  = makeCtl(2'd2, 1'b1, 1'b1);
        tEn = 1'b1;
        vA  = wordW'(randomWord());
        vB  = randomWord();
        vX  = randomWord();
        step();
        idleControls();
        cA  = makeCtl(2'd0, 1'b1, 1'b0);
        cB  = makeCtl(2'd1, 1'b1, 1'b0);
        cX  = makeCtl(2'd2, 1'b1, 1'b0);
        tEn = 1'b1;
        step();
        finishTest("simultaneous", errBefore);
    endtask

    task automatic checkIdlePorts();
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < numRegs; i++) begin
            idleControls();
            cX = makeCtl(bb1Pkg::regAddr_t'(i), 1'b1, 1'b1);
            vX = randomWord();
            step();
        end
        idleControls();                 // Enables low
        cA = makeCtl(bb1Pkg::instrReg, 1'b0, 1'b0);
        cB = cA;
        cX = cA;
        step();
        checkField("qA", word_t'(qA), '0);
        checkField("qB", qB, '0);
        checkField("qX", qX, '0);
        idleControls();                 // All three writing
        cA  = makeCtl(2'd0, 1'b1, 1'b1);
        cB  = makeCtl(2'd3, 1'b1, 1'b1);
        cX  = makeCtl(2'd2, 1'b1, 1'b1);
        tEn = 1'b1;
        vA  = wordW'(randomWord());
        vB  = randomWord();
        vX  = randomWord();
        step();
        checkField("qA", word_t'(qA), '0);
        checkField("qB", qB, '0);
        checkField("qX", qX, '0);
        idleControls();
        cB  = makeCtl(2'd2, 1'b0, 1'b0);  // Tag half reads on its own
        tEn = 1'b1;
        step();
        finishTest("idle ports", errBefore);
    endtask

`endif

/* extBusTb.sv */
// ############################################################################
// Testbench for the external bus register file.
// Drives the bus through directed tests, keeps a reference copy of the four
// registers and compares every output at each falling clock edge.
// The directed test tasks live in the included test file.
// Prints one line per test, then a summary line and the final verdict.
// ############################################################################
`timescale 1ns/10ps

module extBusTb;

    localparam int clkPeriod    = 100;
    localparam int resetCycles  = 10;
    // Cycles per test: reset, write/read, tags, simultaneous, idle ports
    localparam int testCycles   = 10 + 24 + 10 + 4 + 7;
    localparam int marginCycles = 50;

    localparam int wordW   = bb1Pkg::wordW;
    localparam int fullW   = bb1Pkg::fullW;
    localparam int numRegs = 4;

    typedef logic [fullW-1:0] word_t;

    // DUT inputs
    logic            clk;
    logic            rst;
    logic [wordW-1:0] dA;
    word_t           dB;
    word_t           dX;
    bb1Pkg::busCtl_t ctlA;
    bb1Pkg::busCtl_t ctlB;
    bb1Pkg::busCtl_t ctlX;
    logic            tagEnB;

    // DUT outputs
    logic [wordW-1:0]       qA;
    word_t                  qB;
    word_t                  qX;
    logic [wordW-1:0]       iword;
    logic [bb1Pkg::tagW-1:0] itag;
    logic [bb1Pkg::tagW-1:0] dtag;

    // Values for the next cycle, set up by the tests
    bb1Pkg::busCtl_t cA;
    bb1Pkg::busCtl_t cB;
    bb1Pkg::busCtl_t cX;
    logic            tEn;
    logic [wordW-1:0] vA;
    word_t           vB;
    word_t           vX;
    logic            doRst;

    word_t       refMem [numRegs];  // Expected register contents
    logic [31:0] rngState;
    int          errors;
    int          testsPassed;
    int          testsFailed;

    extBus u_dut (
        .clk    (clk),
        .rst    (rst),
        .dA     (dA),
        .dB     (dB),
        .dX     (dX),
        .ctlA   (ctlA),
        .ctlB   (ctlB),
        .ctlX   (ctlX),
        .tagEnB (tagEnB),
        .qA     (qA),
        .qB     (qB),
        .qX     (qX),
        .iword  (iword),
        .itag   (itag),
        .dtag   (dtag)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Three 24-bit chunks make one 72-bit word
    function automatic word_t randomWord();
        word_t w;
        for (int i = 0; i < 3; i++) begin
            rngState = nextRand(rngState);
            w[i*24 +: 24] = rngState[23:0];
        end
        return w;
    endfunction

    function automatic bb1Pkg::busCtl_t makeCtl(input bb1Pkg::regAddr_t addr,
                                                input logic en, input logic wr);
        bb1Pkg::busCtl_t c;
        c.addr = addr;
        c.en   = en;
        c.wr   = wr;
        return c;
    endfunction

    task automatic idleControls();
        cA    = '0;
        cB    = '0;
        cX    = '0;
        tEn   = 1'b0;
        vA    = '0;
        vB    = '0;
        vX    = '0;
        doRst = 1'b0;
    endtask

    task automatic checkField(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Reads show the contents before this cycle's writes
    task automatic checkOutputs();
        word_t expA;
        word_t expB;
        word_t expX;
        expA = '0;
        expB = '0;
        expX = '0;
        if (cA.en && !cA.wr)
            expA[wordW-1:0] = refMem[cA.addr][wordW-1:0];
        if (cB.en && !cB.wr)
            expB[wordW-1:0] = refMem[cB.addr][wordW-1:0];
        if (tEn && !cB.wr)
            expB[fullW-1:wordW] = refMem[cB.addr][fullW-1:wordW];  // Tag half follows tagEnB
        if (cX.en && !cX.wr)
            expX = refMem[cX.addr];
        checkField("qA", word_t'(qA), expA);
        checkField("qB", qB, expB);
        checkField("qX", qX, expX);
        checkField("iword", word_t'(iword), word_t'(refMem[bb1Pkg::instrReg][wordW-1:0]));
        checkField("itag", word_t'(itag), word_t'(refMem[bb1Pkg::instrReg][fullW-1:wordW]));
        checkField("dtag", word_t'(dtag), word_t'(refMem[bb1Pkg::tagReg][fullW-1:wordW]));
    endtask

    task automatic updateModel();
        word_t nxt;
        for (int i = 0; i < numRegs; i++) begin
            nxt = refMem[i];
            if (doRst) begin
                nxt = '0;
            end else begin
                if (cA.en && cA.wr && int'(cA.addr) == i)
                    nxt[wordW-1:0] = vA;                // Data half only
                if (cB.en && cB.wr && int'(cB.addr) == i)
                    nxt[wordW-1:0] = vB[wordW-1:0];
                if (tEn && cB.wr && int'(cB.addr) == i)
                    nxt[fullW-1:wordW] = vB[fullW-1:wordW];
                if (cX.en && cX.wr && int'(cX.addr) == i)
                    nxt = vX;                           // X beats B beats A
            end
            refMem[i] = nxt;
        end
    endtask

    // One bus cycle: drive on the rising edge, check on the falling edge
    task automatic step();
        @(posedge clk);
        ctlA   <= cA;
        ctlB   <= cB;
        ctlX   <= cX;
        tagEnB <= tEn;
        dA     <= vA;
        dB     <= vB;
        dX     <= vX;
        rst    <= doRst;
        @(negedge clk);
        checkOutputs();
        updateModel();
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            testsPassed++;
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: %0d mismatches", name, errors - errBefore);
        end
    endtask

    `include "extBusTests.svh"

    initial begin
        clk    = 1'b0;
        rst    <= 1'b1;
        ctlA   <= '0;
        ctlB   <= '0;
        ctlX   <= '0;
        tagEnB <= 1'b0;
        dA     <= '0;
        dB     <= '0;
        dX     <= '0;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        rngState    = 32'd21;
        idleControls();
        for (int i = 0; i < numRegs; i++) begin
            refMem[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        checkReset();
        checkWriteRead();
        checkTags();
        checkSimultaneous();
        checkIdlePorts();

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 testsPassed, testsFailed, errors);
        if (testsFailed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((resetCycles + testCycles + marginCycles) * clkPeriod);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
bb1Pkg.sv
bb1Slice.sv
extBus.sv
extBusTb.sv
